// ==== lwe_enc_top.f ====
verilog/lwe_pkg.sv
verilog/mem_port_if.sv
verilog/coef_ram.sv
verilog/lwe_regs.sv
verilog/enc_addr_seq.sv
verilog/row_mac.sv
verilog/lwe_enc_top.sv
verification/lwe_enc_asserts.sv
verification/tb_lwe_enc.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the lwe_enc_top testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_lwe_enc \
   -f lwe_enc_top.f -o tb_lwe_enc > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_lwe_enc > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "sim failed" sim.log && exit 1
exit 0

// ==== verification/lwe_enc_asserts.sv ====
`timescale 1ns/100ps

// bus handshake and status rules, bound into lwe_regs
module lwe_enc_asserts (
   input logic clk_100mhz,
   input logic sys_rst,
   input logic wb_cyc,
   input logic wb_stb,
   input logic wb_ack,
   input logic busy,
   input logic done_flag
);

   // ack lasts exactly one cycle
   ack_one_cycle: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
      wb_ack |=> !wb_ack)
      else $error("wb_ack high in two consecutive cycles");

   ack_after_req: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
      wb_ack |-> $past(wb_cyc && wb_stb))   // request seen one cycle earlier
      else $error("wb_ack without a preceding cyc and stb");

   status_excl: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
      !(busy && done_flag))
      else $error("busy and done set together");

endmodule

bind lwe_regs lwe_enc_asserts asrt0 (
   .clk_100mhz, .sys_rst, .wb_cyc, .wb_stb, .wb_ack, .busy, .done_flag
);

// ==== verification/tb_lwe_enc.sv ====
`timescale 1ns/100ps

module tb_lwe_enc;

   localparam int ROWS       = 6;     // dut defaults
   localparam int N_PAIRS    = 4;
   localparam int ACK_WAIT   = 20;    // cycles per bus access
   localparam int DONE_POLLS = 100;   // status reads per run

   logic                       clk_100mhz;
   logic                       sys_rst;
   logic                       wb_cyc;
   logic                       wb_stb;
   logic                       wb_we;
   logic [lwe_pkg::ADR_W-1:0]  wb_adr;
   lwe_pkg::word_t             wb_dat_w;
   lwe_pkg::word_t             wb_dat_r;
   logic                       wb_ack;

   logic [31:0]    lfsr_state;
   lwe_pkg::word_t a_mem [ROWS*N_PAIRS];   // shadow copies of what the host loaded
   lwe_pkg::word_t s_mem [N_PAIRS];
   lwe_pkg::word_t e_mem [ROWS];
   int             errors;
   int             checks;
   int             tests;

   lwe_enc_top dut0 (
      .clk_100mhz, .sys_rst,
      .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack
   );

   initial clk_100mhz = 1'b0;
   always #5 clk_100mhz = ~clk_100mhz;   // 100 MHz

   // galois lfsr with taps of x^32+x^22+x^2+x+1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      logic [31:0] n;
      n = s >> 1;
      if (s[0]) n = n ^ 32'h8020_0003;
      return n;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r = {r[30:0], lfsr_state[0]};   // one step per bit
         lfsr_state = lfsr_step(lfsr_state);
      end
      return r;
   endfunction

   function automatic logic [lwe_pkg::ADR_W-1:0] bus_adr(input lwe_pkg::region_e rgn,
                                                         input int idx);
      logic [lwe_pkg::IDX_W-1:0] i;
      i = idx[lwe_pkg::IDX_W-1:0];
      return {rgn, i};
   endfunction

   // coefficient j of a packed word with odd j in the upper half
   function automatic lwe_pkg::coef_t coef_of(input lwe_pkg::word_t w, input int j);
      return (j % 2 == 1) ? w[31:16] : w[15:0];
   endfunction

   // b[i] = sum A[i][j]*s[j] + e[i] mod 2^16
   function automatic lwe_pkg::coef_t model_b(input int i);
      lwe_pkg::coef_t acc;
      lwe_pkg::coef_t prod;
      acc = e_mem[i][15:0];
      for (int j = 0; j < 2 * N_PAIRS; j++) begin
         prod = coef_of(a_mem[i*N_PAIRS + j/2], j) * coef_of(s_mem[j/2], j);
         acc  = acc + prod;
      end
      return acc;
   endfunction

   function automatic lwe_pkg::word_t stat_word(input logic busy, input logic done);
      lwe_pkg::word_t w;
      w = '0;
      w[lwe_pkg::STAT_BUSY_BIT] = busy;
      w[lwe_pkg::STAT_DONE_BIT] = done;
      return w;
   endfunction

   task automatic check(input string name, input lwe_pkg::word_t got,
                        input lwe_pkg::word_t want);
      checks++;
      if (got !== want) begin
         errors++;
         $display("Error at %0d ns: %s = %h, expected %h", $time, name, got, want);
      end
   endtask

   // one classic cycle with ack sampled mid cycle
   task automatic bus_cycle(input logic we, input logic [lwe_pkg::ADR_W-1:0] adr,
                            input lwe_pkg::word_t wdata, output lwe_pkg::word_t rdata);
      int n;
      n     = 0;
      rdata = '0;
      @(posedge clk_100mhz);
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      wb_we    <= we;
      wb_adr   <= adr;
      wb_dat_w <= wdata;
      @(negedge clk_100mhz);
      while (!wb_ack && n < ACK_WAIT) begin
         @(negedge clk_100mhz);
         n++;
      end
      if (wb_ack) begin
         rdata = wb_dat_r;   // valid with ack
      end else begin
         errors++;
         $display("no wishbone ack for address %h by %0d ns", adr, $time);
      end
      @(posedge clk_100mhz);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
   endtask

   task automatic wb_write(input logic [lwe_pkg::ADR_W-1:0] adr, input lwe_pkg::word_t data);
      lwe_pkg::word_t unused;
      bus_cycle(1'b1, adr, data, unused);
   endtask

   task automatic wb_read(input logic [lwe_pkg::ADR_W-1:0] adr, output lwe_pkg::word_t data);
      bus_cycle(1'b0, adr, '0, data);
   endtask

   task automatic load_a();
      for (int w = 0; w < ROWS * N_PAIRS; w++) begin
         a_mem[w] = rand_bits(32);
         wb_write(bus_adr(lwe_pkg::region_a, w), a_mem[w]);
      end
   endtask

   task automatic load_s();
      for (int w = 0; w < N_PAIRS; w++) begin
         s_mem[w] = rand_bits(32);
         wb_write(bus_adr(lwe_pkg::region_s, w), s_mem[w]);
      end
   endtask

   task automatic load_e();
      for (int w = 0; w < ROWS; w++) begin
         e_mem[w] = rand_bits(32);   // upper half is don't care for the engine
         wb_write(bus_adr(lwe_pkg::region_e_b, w), e_mem[w]);
      end
   endtask

   task automatic start_run();
      lwe_pkg::word_t w;
      w = '0;
      w[lwe_pkg::CTRL_START_BIT] = 1'b1;
      wb_write(bus_adr(lwe_pkg::region_ctrl, 0), w);
   endtask

   // bounded poll of status until done
   task automatic wait_done();
      lwe_pkg::word_t st;
      int             polls;
      st    = '0;
      polls = 0;
      while (!st[lwe_pkg::STAT_DONE_BIT] && polls < DONE_POLLS) begin
         wb_read(bus_adr(lwe_pkg::region_ctrl, 0), st);
         polls++;
      end
      if (!st[lwe_pkg::STAT_DONE_BIT]) begin
         errors++;
         $display("engine never reported done by %0d ns", $time);
      end
      check("status", st, stat_word(1'b0, 1'b1));
   endtask

   task automatic check_b();
      lwe_pkg::word_t got;
      for (int i = 0; i < ROWS; i++) begin
         wb_read(bus_adr(lwe_pkg::region_e_b, 2048 + i), got);   // b half of the region
         check($sformatf("b[%0d]", i), got, {16'h0000, model_b(i)});
      end
   endtask

   task automatic end_test(input string name, input int mark);
      tests++;
      $display("test %0d %s: %0d errors", tests, name, errors - mark);
   endtask

   initial begin
      int             mark;
      lwe_pkg::word_t got;
      lfsr_state = 32'hb9a2;
      errors     = 0;
      checks     = 0;
      tests      = 0;
      sys_rst  <= 1'b1;
      wb_cyc   <= 1'b0;
      wb_stb   <= 1'b0;
      wb_we    <= 1'b0;
      wb_adr   <= '0;
      wb_dat_w <= '0;
      repeat (3) @(posedge clk_100mhz);
      sys_rst <= 1'b0;

      mark = errors;
      wb_read(bus_adr(lwe_pkg::region_ctrl, 0), got);
      check("status", got, '0);
      end_test("status after reset", mark);

      mark = errors;
      load_a();
      load_s();
      load_e();
      for (int w = 0; w < ROWS * N_PAIRS; w++) begin
         wb_read(bus_adr(lwe_pkg::region_a, w), got);
         check($sformatf("a[%0d]", w), got, a_mem[w]);
      end
      for (int w = 0; w < N_PAIRS; w++) begin
         wb_read(bus_adr(lwe_pkg::region_s, w), got);
         check($sformatf("s[%0d]", w), got, s_mem[w]);
      end
      for (int w = 0; w < ROWS; w++) begin
         wb_read(bus_adr(lwe_pkg::region_e_b, w), got);
         check($sformatf("e[%0d]", w), got, e_mem[w]);
      end
      end_test("memory readback", mark);

      mark = errors;
      start_run();
      wait_done();
      check_b();
      end_test("first encryption", mark);

      mark = errors;
      load_a();
      load_e();
      start_run();
      wb_read(bus_adr(lwe_pkg::region_ctrl, 0), got);
      check("status", got, stat_word(1'b1, 1'b0));   // busy with the old done gone
      start_run();   // lands while busy
      wait_done();
      check_b();
      end_test("start while busy", mark);

      mark = errors;
      load_s();
      start_run();
      wb_read(bus_adr(lwe_pkg::region_ctrl, 0), got);
      check("status", got, stat_word(1'b1, 1'b0));
      wait_done();
      check_b();
      end_test("new secret rerun", mark);

      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

// ==== verilog/coef_ram.sv ====
`timescale 1ns/100ps

// true dual port ram, read first on both ports
module coef_ram #(
   parameter int ADDR_W = 4
) (
   input logic       clk_100mhz,
   mem_port_if.ram   port_a,   // bus side
   mem_port_if.ram   port_b    // engine side
);

   localparam int DEPTH = 1 << ADDR_W;

   lwe_pkg::word_t mem [DEPTH];   // no init, host loads it

   // both ports in one block so the array has a single driver
   always_ff @(posedge clk_100mhz) begin
      if (port_a.en) begin
         port_a.rdata <= mem[port_a.addr];   // old data on a write
         if (port_a.we) begin
            mem[port_a.addr] <= port_a.wdata;
         end
      end
      if (port_b.en) begin
         port_b.rdata <= mem[port_b.addr];
         if (port_b.we) begin
            mem[port_b.addr] <= port_b.wdata;
         end
      end
   end

endmodule

// ==== verilog/enc_addr_seq.sv ====
`timescale 1ns/100ps

// walks rows and coefficient pairs, one read per cycle
module enc_addr_seq #(
   parameter int ROWS    = 6,
   parameter int N_PAIRS = 4
) (
   input  logic            clk_100mhz,
   input  logic            sys_rst,
   input  logic            start,
   mem_port_if.host        a_rd,
   mem_port_if.host        s_rd,
   mem_port_if.host        e_rd,
   output logic            valid,       // a read was issued this cycle
   output logic            last_pair,   // last pair of a row
   output logic            last_row,    // whole last row
   output lwe_pkg::idx_t   row
);

   localparam int A_AW = lwe_pkg::aw(ROWS * N_PAIRS);
   localparam int S_AW = lwe_pkg::aw(N_PAIRS);
   localparam int E_AW = lwe_pkg::aw(ROWS);

   logic          running;
   lwe_pkg::idx_t row_cnt;
   lwe_pkg::idx_t pair_cnt;
   lwe_pkg::idx_t a_lin;   // row-major word index into A
   logic          at_pair_end;
   logic          at_row_end;

   assign at_pair_end = (pair_cnt == lwe_pkg::idx_t'(N_PAIRS - 1));
   assign at_row_end  = (row_cnt == lwe_pkg::idx_t'(ROWS - 1));
   assign a_lin       = row_cnt * lwe_pkg::idx_t'(N_PAIRS) + pair_cnt;

   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         running  <= 1'b0;
         row_cnt  <= '0;
         pair_cnt <= '0;
      end else if (start && !running) begin
         running  <= 1'b1;
         row_cnt  <= '0;
         pair_cnt <= '0;
      end else if (running) begin
         if (at_pair_end) begin
            pair_cnt <= '0;
            if (at_row_end) begin
               running <= 1'b0;   // matrix done
            end else begin
               row_cnt <= row_cnt + 1'b1;
            end
         end else begin
            pair_cnt <= pair_cnt + 1'b1;
         end
      end
   end

   assign valid     = running;
   assign last_pair = running && at_pair_end;
   assign last_row  = running && at_row_end;
   assign row       = row_cnt;

   // engine side of A, s and e is read only
   assign a_rd.en    = running;
   assign a_rd.we    = 1'b0;
   assign a_rd.addr  = a_lin[A_AW-1:0];
   assign a_rd.wdata = '0;

   assign s_rd.en    = running;
   assign s_rd.we    = 1'b0;
   assign s_rd.addr  = pair_cnt[S_AW-1:0];
   assign s_rd.wdata = '0;

   assign e_rd.en    = last_pair;   // e only needed at the row end
   assign e_rd.we    = 1'b0;
   assign e_rd.addr  = row_cnt[E_AW-1:0];
   assign e_rd.wdata = '0;

endmodule

// ==== verilog/lwe_enc_top.sv ====
`timescale 1ns/100ps

module lwe_enc_top #(
   parameter int ROWS    = 6,   // rows of A
   parameter int N_PAIRS = 4    // words per row, dimension is twice this
) (
   input  logic                       clk_100mhz,
   input  logic                       sys_rst,
   input  logic                       wb_cyc,
   input  logic                       wb_stb,
   input  logic                       wb_we,
   input  logic [lwe_pkg::ADR_W-1:0]  wb_adr,
   input  lwe_pkg::word_t             wb_dat_w,
   output lwe_pkg::word_t             wb_dat_r,
   output logic                       wb_ack
);

   localparam int A_AW = lwe_pkg::aw(ROWS * N_PAIRS);
   localparam int S_AW = lwe_pkg::aw(N_PAIRS);
   localparam int E_AW = lwe_pkg::aw(ROWS);   // one e per word
   localparam int B_AW = lwe_pkg::aw(ROWS);

   logic          start;
   logic          done;
   logic          valid;
   logic          last_pair;
   logic          last_row;
   lwe_pkg::idx_t row;

   // host side is the bus, eng side the datapath
   mem_port_if #(.ADDR_W(A_AW)) a_host ();
   mem_port_if #(.ADDR_W(A_AW)) a_eng ();
   mem_port_if #(.ADDR_W(S_AW)) s_host ();
   mem_port_if #(.ADDR_W(S_AW)) s_eng ();
   mem_port_if #(.ADDR_W(E_AW)) e_host ();
   mem_port_if #(.ADDR_W(E_AW)) e_eng ();
   mem_port_if #(.ADDR_W(B_AW)) b_host ();
   mem_port_if #(.ADDR_W(B_AW)) b_eng ();

   lwe_regs #(.ROWS(ROWS), .N_PAIRS(N_PAIRS)) regs0 (
      .clk_100mhz, .sys_rst,
      .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
      .a_bus(a_host), .s_bus(s_host), .e_bus(e_host), .b_bus(b_host),
      .start, .done
   );

   coef_ram #(.ADDR_W(A_AW)) ram_a (.clk_100mhz, .port_a(a_host), .port_b(a_eng));
   coef_ram #(.ADDR_W(S_AW)) ram_s (.clk_100mhz, .port_a(s_host), .port_b(s_eng));
   coef_ram #(.ADDR_W(E_AW)) ram_e (.clk_100mhz, .port_a(e_host), .port_b(e_eng));
   coef_ram #(.ADDR_W(B_AW)) ram_b (.clk_100mhz, .port_a(b_host), .port_b(b_eng));

   enc_addr_seq #(.ROWS(ROWS), .N_PAIRS(N_PAIRS)) seq0 (
      .clk_100mhz, .sys_rst, .start,
      .a_rd(a_eng), .s_rd(s_eng), .e_rd(e_eng),
      .valid, .last_pair, .last_row, .row
   );

   row_mac #(.ROWS(ROWS)) mac0 (
      .clk_100mhz, .sys_rst,
      .valid, .last_pair, .last_row, .row,
      .a_data(a_eng.rdata), .s_data(s_eng.rdata), .e_data(e_eng.rdata),
      .b_wr(b_eng),
      .done
   );

endmodule

// ==== verilog/lwe_pkg.sv ====
package lwe_pkg;

   // coefficient and word widths
   parameter int COEF_W = 16;   // mod 2^16 by truncation
   parameter int WORD_W = 32;   // bus and ram word

   // wishbone word address split
   parameter int IDX_W = 12;    // index inside one region
   parameter int ADR_W = 14;    // top 2 bits pick the region

   typedef logic [COEF_W-1:0] coef_t;
   typedef logic [WORD_W-1:0] word_t;
   typedef logic [IDX_W-1:0]  idx_t;

   // one word seen as raw bits or as two coefficients
   typedef union packed {
      word_t raw;               // bus and ram view
      struct packed {
         coef_t hi;             // odd index
         coef_t lo;             // even index
      } pair;                   // datapath view
   } coef_pair_u;

   typedef enum logic [1:0] {
      region_ctrl = 2'd0,
      region_a    = 2'd1,
      region_s    = 2'd2,
      region_e_b  = 2'd3        // e below index 2048, b from 2048 up
   } region_e;

   // control and status word bits
   parameter int CTRL_START_BIT = 0;
   parameter int STAT_BUSY_BIT  = 1;
   parameter int STAT_DONE_BIT  = 2;

   // ram address bits for a given depth, at least one
   function automatic int aw(int depth);
      return (depth > 1) ? $clog2(depth) : 1;
   endfunction

endpackage

// ==== verilog/lwe_regs.sv ====
`timescale 1ns/100ps

module lwe_regs #(
   parameter int ROWS    = 6,
   parameter int N_PAIRS = 4
) (
   input  logic                       clk_100mhz,
   input  logic                       sys_rst,
   input  logic                       wb_cyc,
   input  logic                       wb_stb,
   input  logic                       wb_we,
   input  logic [lwe_pkg::ADR_W-1:0]  wb_adr,
   input  lwe_pkg::word_t             wb_dat_w,
   output lwe_pkg::word_t             wb_dat_r,
   output logic                       wb_ack,
   mem_port_if.host                   a_bus,
   mem_port_if.host                   s_bus,
   mem_port_if.host                   e_bus,
   mem_port_if.host                   b_bus,
   output logic                       start,   // one cycle pulse to the sequencer
   input  logic                       done     // last row written
);

   localparam int A_AW = lwe_pkg::aw(ROWS * N_PAIRS);
   localparam int S_AW = lwe_pkg::aw(N_PAIRS);
   localparam int E_AW = lwe_pkg::aw(ROWS);
   localparam int B_AW = lwe_pkg::aw(ROWS);

   lwe_pkg::region_e region;
   lwe_pkg::region_e rd_region;   // region of the access in flight
   lwe_pkg::idx_t    idx;
   logic             req;
   logic             hit_b;       // upper half of the e_b region
   logic             rd_b;
   logic             busy;
   logic             done_flag;
   logic             start_wr;
   lwe_pkg::word_t   status;
   lwe_pkg::word_t   rd_stat;

   assign region = lwe_pkg::region_e'(wb_adr[lwe_pkg::ADR_W-1 -: 2]);
   assign idx    = wb_adr[lwe_pkg::IDX_W-1:0];
   assign hit_b  = idx[lwe_pkg::IDX_W-1];
   assign req    = wb_cyc && wb_stb && !wb_ack;   // ack cycle never starts a second access

   // start request on ctrl index 0, dropped while busy
   assign start_wr = req && wb_we && (region == lwe_pkg::region_ctrl) && (idx == '0)
                     && wb_dat_w[lwe_pkg::CTRL_START_BIT] && !busy;

   always_comb begin
      status = '0;
      status[lwe_pkg::STAT_BUSY_BIT] = busy;
      status[lwe_pkg::STAT_DONE_BIT] = done_flag;
   end

   // port a of each ram, read starts in the request cycle
   assign a_bus.en    = req && (region == lwe_pkg::region_a);
   assign a_bus.we    = a_bus.en && wb_we;
   assign a_bus.addr  = idx[A_AW-1:0];
   assign a_bus.wdata = wb_dat_w;

   assign s_bus.en    = req && (region == lwe_pkg::region_s);
   assign s_bus.we    = s_bus.en && wb_we;
   assign s_bus.addr  = idx[S_AW-1:0];
   assign s_bus.wdata = wb_dat_w;

   assign e_bus.en    = req && (region == lwe_pkg::region_e_b) && !hit_b;
   assign e_bus.we    = e_bus.en && wb_we;
   assign e_bus.addr  = idx[E_AW-1:0];
   assign e_bus.wdata = wb_dat_w;

   assign b_bus.en    = req && (region == lwe_pkg::region_e_b) && hit_b;
   assign b_bus.we    = 1'b0;                // b is read only from the bus
   assign b_bus.addr  = idx[B_AW-1:0];       // bit 11 dropped
   assign b_bus.wdata = '0;

   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         wb_ack    <= 1'b0;
         start     <= 1'b0;
         busy      <= 1'b0;
         done_flag <= 1'b0;
      end else begin
         wb_ack <= req;   // single ack, one cycle later
         start  <= start_wr;
         if (start_wr) begin
            busy      <= 1'b1;
            done_flag <= 1'b0;   // cleared by each new run
         end else if (done) begin
            busy      <= 1'b0;
            done_flag <= 1'b1;   // sticky until next start
         end
      end
   end

   // read return select, captured with the request
   always_ff @(posedge clk_100mhz) begin
      if (req) begin
         rd_region <= region;
         rd_b      <= hit_b;
         rd_stat   <= (idx == '0) ? status : '0;   // other ctrl indices read 0
      end
   end

   always_comb begin
      case (rd_region)
         lwe_pkg::region_a:   wb_dat_r = a_bus.rdata;
         lwe_pkg::region_s:   wb_dat_r = s_bus.rdata;
         lwe_pkg::region_e_b: wb_dat_r = rd_b ? b_bus.rdata : e_bus.rdata;
         default:             wb_dat_r = rd_stat;
      endcase
   end

endmodule

// ==== verilog/mem_port_if.sv ====
`timescale 1ns/100ps

// one port of a coef_ram
interface mem_port_if #(
   parameter int ADDR_W = 4
);
   logic                en;      // access strobe
   logic                we;      // write when en
   logic [ADDR_W-1:0]   addr;
   lwe_pkg::word_t      wdata;
   lwe_pkg::word_t      rdata;   // valid one cycle after en

   modport host (
      output en, we, addr, wdata,
      input  rdata
   );

   modport ram (
      input  en, we, addr, wdata,
      output rdata
   );
endinterface

// ==== verilog/row_mac.sv ====
`timescale 1ns/100ps

// pair products, row accumulate, add e, write b
module row_mac #(
   parameter int ROWS = 6
) (
   input  logic            clk_100mhz,
   input  logic            sys_rst,
   input  logic            valid,
   input  logic            last_pair,
   input  logic            last_row,
   input  lwe_pkg::idx_t   row,
   input  lwe_pkg::word_t  a_data,
   input  lwe_pkg::word_t  s_data,
   input  lwe_pkg::word_t  e_data,
   mem_port_if.host        b_wr,
   output logic            done   // with the write of the last row
);

   localparam int B_AW = lwe_pkg::aw(ROWS);

   lwe_pkg::coef_pair_u a_w;
   lwe_pkg::coef_pair_u s_w;
   lwe_pkg::coef_pair_u e_w;
   lwe_pkg::coef_pair_u b_w;

   // stage 1 lines up with ram data
   logic            v1;
   logic            lp1;
   logic            lr1;
   lwe_pkg::idx_t   row1;
   // stage 2 holds the products
   logic            v2;
   logic            lp2;
   logic            lr2;
   lwe_pkg::idx_t   row2;
   lwe_pkg::coef_t  psum2;
   lwe_pkg::coef_t  e2;
   // stage 3 accumulate and write
   lwe_pkg::coef_t  acc;
   logic            wr_q;
   logic [B_AW-1:0] wr_addr;
   lwe_pkg::coef_t  wr_coef;

   assign a_w.raw = a_data;
   assign s_w.raw = s_data;
   assign e_w.raw = e_data;   // e sits in the low half

   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         v1   <= 1'b0;
         lp1  <= 1'b0;
         lr1  <= 1'b0;
         v2   <= 1'b0;
         lp2  <= 1'b0;
         lr2  <= 1'b0;
         acc  <= '0;
         wr_q <= 1'b0;
         done <= 1'b0;
      end else begin
         v1   <= valid;
         lp1  <= last_pair;
         lr1  <= last_row;
         v2   <= v1;
         lp2  <= lp1;
         lr2  <= lr1;
         wr_q <= v2 && lp2;
         done <= v2 && lp2 && lr2;
         if (v2) begin
            acc <= lp2 ? '0 : acc + psum2;   // next row starts from zero
         end
      end
   end

   always_ff @(posedge clk_100mhz) begin
      row1    <= row;
      row2    <= row1;
      psum2   <= a_w.pair.hi * s_w.pair.hi + a_w.pair.lo * s_w.pair.lo;   // wraps mod 2^16
      e2      <= e_w.pair.lo;
      wr_coef <= acc + psum2 + e2;   // only used on the last pair
      wr_addr <= row2[B_AW-1:0];
   end

   always_comb begin
      b_w.pair.hi = '0;
      b_w.pair.lo = wr_coef;
   end

   assign b_wr.en    = wr_q;
   assign b_wr.we    = wr_q;
   assign b_wr.addr  = wr_addr;
   assign b_wr.wdata = b_w.raw;

endmodule
